//--- include/vscale_defines.svh
`ifndef VSCALE_DEFINES_SVH
`define VSCALE_DEFINES_SVH

// pixel and resolution widths
`define VSCALE_PIX_W      8
`define VSCALE_RESO_W     10

// line fifo depth, also the widest line
`define VSCALE_FIFO_DEPTH 64

// axi4-lite port widths
`define VSCALE_AXIL_AW    8
`define VSCALE_AXIL_DW    32

// register byte offsets
`define VSCALE_REG_CTRL    8'h00
`define VSCALE_REG_OWIDTH  8'h04
`define VSCALE_REG_OHEIGHT 8'h08
`define VSCALE_REG_SHEIGHT 8'h0C
`define VSCALE_REG_STATUS  8'h10

`endif

//--- hdl/vscale_pkg.sv
`default_nettype none

`include "vscale_defines.svh"

package vscale_pkg;

	typedef logic [`VSCALE_PIX_W-1:0]      pix_t;
	typedef logic [`VSCALE_RESO_W-1:0]     reso_t;
	// doubled cross-multiplied line centres
	typedef logic [2*`VSCALE_RESO_W+1:0]   pos_t;
	typedef logic [`VSCALE_AXIL_AW-1:0]    axil_addr_t;
	typedef logic [`VSCALE_AXIL_DW-1:0]    axil_data_t;

	// one stream beat
	typedef struct packed {
		logic eol;
		logic sof;
		pix_t data;
	} pix_beat_t;

	// word kept in the line fifos
	typedef struct packed {
		logic eol;
		logic sof;
		pix_t data;
	} fifo_word_t;

	typedef enum logic {
		AXIL_IDLE,
		AXIL_RESP
	} axil_state_t;

	typedef struct packed {
		reso_t ori_width;
		reso_t ori_height;
		reso_t scale_height;
	} vscale_cfg_t;

endpackage

`default_nettype wire

//--- hdl/line_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "vscale_defines.svh"

module line_fifo import vscale_pkg::*; #(
	parameter int DEPTH = `VSCALE_FIFO_DEPTH
) (
	input  wire        clk,
	input  wire        int_resetn,
	input  wire        i_clear,
	input  wire        i_wr_en,
	input  fifo_word_t i_wr_data,
	input  wire        i_rd_en,
	output fifo_word_t o_rd_data,
	output logic       o_full,
	output logic       o_empty
);

	localparam int AW = $clog2(DEPTH);

	fifo_word_t mem [DEPTH];
	// one extra bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	always_ff @(posedge clk) begin
		if (!int_resetn || i_clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (i_wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[wr_ptr[AW-1:0]] <= i_wr_data;
		end
	end

	// registered read port
	always_ff @(posedge clk) begin
		if (i_rd_en) begin
			o_rd_data <= mem[rd_ptr[AW-1:0]];
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!int_resetn || i_clear)
		!(i_wr_en && o_full));
	a_no_underflow: assert property (@(posedge clk) disable iff (!int_resetn || i_clear)
		!(i_rd_en && o_empty));

endmodule

`default_nettype wire

//--- hdl/vscale_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "vscale_defines.svh"

module vscale_regs import vscale_pkg::*; (
	input  wire         clk,
	input  wire         int_resetn,
	input  wire         i_awvalid,
	input  axil_addr_t  i_awaddr,
	output logic        o_awready,
	input  wire         i_wvalid,
	input  axil_data_t  i_wdata,
	output logic        o_wready,
	output logic        o_bvalid,
	output logic [1:0]  o_bresp,
	input  wire         i_bready,
	input  wire         i_arvalid,
	input  axil_addr_t  i_araddr,
	output logic        o_arready,
	output logic        o_rvalid,
	output axil_data_t  o_rdata,
	output logic [1:0]  o_rresp,
	input  wire         i_rready,
	input  wire         i_busy,
	input  wire         i_frame_done,
	output vscale_cfg_t o_cfg,
	output logic        o_frame_start
);

	axil_state_t wr_state;
	axil_state_t rd_state;
	logic        wr_hs;
	logic        rd_hs;
	logic [7:0]  frame_cnt;
	axil_data_t  rd_word;

	////////////////////////////////////////////////////////////
	// write channel
	////////////////////////////////////////////////////////////

	// address and data are taken together
	assign o_awready = (wr_state == AXIL_IDLE) && i_awvalid && i_wvalid;
	assign o_wready  = o_awready;
	assign wr_hs     = o_awready;
	assign o_bvalid  = (wr_state == AXIL_RESP);
	assign o_bresp   = 2'b00;

	always_ff @(posedge clk) begin
		if (!int_resetn) begin
			wr_state      <= AXIL_IDLE;
			o_cfg         <= '0;
			o_frame_start <= 1'b0;
		end else begin
			o_frame_start <= 1'b0;
			if (wr_hs) begin
				wr_state <= AXIL_RESP;
				case (i_awaddr)
					`VSCALE_REG_CTRL:    o_frame_start <= i_wdata[0];
					`VSCALE_REG_OWIDTH:  o_cfg.ori_width <= i_wdata[`VSCALE_RESO_W-1:0];
					`VSCALE_REG_OHEIGHT: o_cfg.ori_height <= i_wdata[`VSCALE_RESO_W-1:0];
					`VSCALE_REG_SHEIGHT: o_cfg.scale_height <= i_wdata[`VSCALE_RESO_W-1:0];
					default: ;
				endcase
			end else if (o_bvalid && i_bready) begin
				wr_state <= AXIL_IDLE;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// read channel
	////////////////////////////////////////////////////////////

	assign o_arready = (rd_state == AXIL_IDLE);
	assign rd_hs     = o_arready && i_arvalid;
	assign o_rvalid  = (rd_state == AXIL_RESP);
	assign o_rresp   = 2'b00;

	always_comb begin
		rd_word = '0;
		case (i_araddr)
			`VSCALE_REG_OWIDTH:  rd_word[`VSCALE_RESO_W-1:0] = o_cfg.ori_width;
			`VSCALE_REG_OHEIGHT: rd_word[`VSCALE_RESO_W-1:0] = o_cfg.ori_height;
			`VSCALE_REG_SHEIGHT: rd_word[`VSCALE_RESO_W-1:0] = o_cfg.scale_height;
			`VSCALE_REG_STATUS: begin
				rd_word[0]    = i_busy;
				rd_word[15:8] = frame_cnt;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!int_resetn) begin
			rd_state <= AXIL_IDLE;
		end else if (rd_hs) begin
			rd_state <= AXIL_RESP;
		end else if (o_rvalid && i_rready) begin
			rd_state <= AXIL_IDLE;
		end
	end

	// read data held until rready
	always_ff @(posedge clk) begin
		if (rd_hs) begin
			o_rdata <= rd_word;
		end
	end

	// completed output frames
	always_ff @(posedge clk) begin
		if (!int_resetn) begin
			frame_cnt <= '0;
		end else if (i_frame_done) begin
			frame_cnt <= frame_cnt + 8'd1;
		end
	end

	a_bvalid_after_write: assert property (@(posedge clk) disable iff (!int_resetn)
		$rose(o_bvalid) |-> $past(i_awvalid && o_awready && i_wvalid && o_wready));

endmodule

`default_nettype wire

//--- hdl/vscale_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "vscale_defines.svh"

module vscale_core import vscale_pkg::*; (
	input  wire         clk,
	input  wire         int_resetn,
	input  vscale_cfg_t i_cfg,
	input  wire         i_frame_start,
	input  wire         i_s_valid,
	input  pix_beat_t   i_s_beat,
	output logic        o_s_ready,
	output logic        o_m_valid,
	output pix_beat_t   o_m_beat,
	input  wire         i_m_ready,
	output logic        o_fifo_rst,
	output logic        o_f0_wr_en,
	output fifo_word_t  o_f0_wr_data,
	output logic        o_f0_rd_en,
	input  fifo_word_t  i_f0_rd_data,
	input  wire         i_f0_full,
	input  wire         i_f0_empty,
	output logic        o_f1_wr_en,
	output fifo_word_t  o_f1_wr_data,
	output logic        o_f1_rd_en,
	input  fifo_word_t  i_f1_rd_data,
	input  wire         i_f1_full,
	input  wire         i_f1_empty,
	output logic        o_busy,
	output logic        o_frame_done
);

	vscale_cfg_t cfg_q;
	logic        load_q;
	pos_t        i_mul, m_mul, o_mul;
	pos_t        two_s, two_h, m_mul_next, o_mul_next, in_limit, w_pos;
	reso_t       s_rem, m_rem, rd_rem;
	logic        f0_line, rd_d1, sof_pend;
	logic        last_src, out_en, keep, s_hs, s_drop;
	logic signed [9:0]  diff;
	logic signed [12:0] w_s, div_s;
	logic signed [22:0] quo, sum;
	pix_t        pix_out;

	////////////////////////////////////////////////////////////
	// line positions
	////////////////////////////////////////////////////////////

	assign two_s      = pos_t'({cfg_q.scale_height, 1'b0});
	assign two_h      = pos_t'({cfg_q.ori_height, 1'b0});
	assign m_mul_next = m_mul + two_s;
	assign o_mul_next = o_mul + two_h;
	// line at f1 head is the last source line
	assign last_src   = (rd_rem == reso_t'(1));
	assign out_en     = (m_mul >= o_mul) || last_src;
	// head line also serves the next output line
	assign keep       = (m_mul >= o_mul_next) || last_src;
	assign in_limit   = keep ? m_mul : m_mul_next;

	// pixels past the last output line are dropped
	assign s_drop     = (m_rem == '0);
	assign o_s_ready  = !i_frame_start && (s_rem != '0) &&
		(s_drop || (!i_f1_full && (i_mul <= in_limit)));
	assign s_hs       = i_s_valid && o_s_ready;

	////////////////////////////////////////////////////////////
	// line fifo steering
	////////////////////////////////////////////////////////////

	assign o_fifo_rst   = i_frame_start;
	// a reused line is read only once it is fully written
	assign o_f1_rd_en   = !i_frame_start && !load_q && (m_rem != '0) && !rd_d1 &&
		!i_f1_empty && (!keep || (i_mul > m_mul)) && (!f0_line || !i_f0_empty) &&
		(!out_en || !o_m_valid || i_m_ready);
	assign o_f0_rd_en   = o_f1_rd_en && f0_line;
	assign o_f1_wr_en   = (s_hs && !s_drop) || (rd_d1 && keep);
	assign o_f1_wr_data = (rd_d1 && keep) ? i_f1_rd_data :
		fifo_word_t'{eol: i_s_beat.eol, sof: i_s_beat.sof, data: i_s_beat.data};
	assign o_f0_wr_en   = rd_d1 && (!keep || f0_line);
	assign o_f0_wr_data = keep ? i_f0_rd_data : i_f1_rd_data;

	// interpolation weight is capped at 2S past the last source centre
	assign w_pos   = (m_mul >= o_mul) ? (o_mul + two_s - m_mul) : two_s;
	assign w_s     = $signed({1'b0, w_pos[11:0]});
	assign div_s   = $signed({1'b0, two_s[11:0]});
	assign diff    = $signed({2'b00, i_f1_rd_data.data}) - $signed({2'b00, i_f0_rd_data.data});
	assign quo     = (diff * w_s) / div_s;
	assign sum     = quo + $signed({15'd0, i_f0_rd_data.data});
	assign pix_out = f0_line ? sum[7:0] : i_f1_rd_data.data;

	assign o_busy  = load_q || (m_rem != '0);

	always_ff @(posedge clk) begin
		if (!int_resetn || i_frame_start) begin
			cfg_q        <= i_frame_start ? i_cfg : '0;
			load_q       <= i_frame_start;
			i_mul        <= '0;
			m_mul        <= '0;
			o_mul        <= '0;
			s_rem        <= '0;
			m_rem        <= '0;
			rd_rem       <= '0;
			f0_line      <= 1'b0;
			rd_d1        <= 1'b0;
			sof_pend     <= 1'b0;
			o_m_valid    <= 1'b0;
			o_frame_done <= 1'b0;
		end else if (load_q) begin
			// configuration captured so the frame can start
			load_q   <= 1'b0;
			i_mul    <= pos_t'(cfg_q.scale_height);
			m_mul    <= pos_t'(cfg_q.scale_height);
			o_mul    <= pos_t'(cfg_q.ori_height);
			s_rem    <= cfg_q.ori_height;
			rd_rem   <= cfg_q.ori_height;
			m_rem    <= cfg_q.scale_height;
			sof_pend <= 1'b1;
		end else begin
			rd_d1        <= o_f1_rd_en;
			o_frame_done <= 1'b0;
			if (s_hs && i_s_beat.eol) begin
				i_mul <= i_mul + two_s;
				s_rem <= s_rem - 1'b1;
			end
			if (o_m_valid && i_m_ready) begin
				o_m_valid <= 1'b0;
			end
			if (rd_d1 && out_en) begin
				o_m_valid <= 1'b1;
				sof_pend  <= 1'b0;
				if (i_f1_rd_data.eol) begin
					m_rem        <= m_rem - 1'b1;
					o_frame_done <= (m_rem == reso_t'(1));
				end
			end
			// end of a line read from f1
			if (rd_d1 && i_f1_rd_data.eol) begin
				if (out_en) begin
					o_mul <= o_mul_next;
				end
				if (!keep) begin
					m_mul   <= m_mul_next;
					rd_rem  <= rd_rem - 1'b1;
					f0_line <= 1'b1;
				end
			end
		end
	end

	// output payload
	always_ff @(posedge clk) begin
		if (rd_d1 && out_en) begin
			o_m_beat.data <= pix_out;
			o_m_beat.sof  <= sof_pend;
			o_m_beat.eol  <= i_f1_rd_data.eol;
		end
	end

	a_m_stable: assert property (@(posedge clk) disable iff (!int_resetn)
		(o_m_valid && !i_m_ready && !i_frame_start) |=> (o_m_valid && $stable(o_m_beat)));
	a_width_fits: assert property (@(posedge clk) disable iff (!int_resetn)
		load_q |-> (cfg_q.ori_width <= `VSCALE_FIFO_DEPTH));
	// f0 never holds more than a line while f1 feeds it
	a_f0_room: assert property (@(posedge clk) disable iff (!int_resetn)
		o_f0_wr_en |-> !i_f0_full);

endmodule

`default_nettype wire

//--- hdl/vscale_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "vscale_defines.svh"

module vscale_top import vscale_pkg::*; (
	input  wire        clk,
	input  wire        int_resetn,
	input  wire        i_awvalid,
	input  axil_addr_t i_awaddr,
	output logic       o_awready,
	input  wire        i_wvalid,
	input  axil_data_t i_wdata,
	output logic       o_wready,
	output logic       o_bvalid,
	output logic [1:0] o_bresp,
	input  wire        i_bready,
	input  wire        i_arvalid,
	input  axil_addr_t i_araddr,
	output logic       o_arready,
	output logic       o_rvalid,
	output axil_data_t o_rdata,
	output logic [1:0] o_rresp,
	input  wire        i_rready,
	input  wire        i_s_valid,
	input  pix_beat_t  i_s_beat,
	output logic       o_s_ready,
	output logic       o_m_valid,
	output pix_beat_t  o_m_beat,
	input  wire        i_m_ready
);

	vscale_cfg_t cfg;
	logic        frame_start, busy, frame_done, fifo_rst;
	logic        f0_wr_en, f0_rd_en, f0_full, f0_empty;
	logic        f1_wr_en, f1_rd_en, f1_full, f1_empty;
	fifo_word_t  f0_wr_data, f0_rd_data, f1_wr_data, f1_rd_data;

	vscale_regs u_regs (
		.clk(clk), .int_resetn(int_resetn),
		.i_awvalid(i_awvalid), .i_awaddr(i_awaddr), .o_awready(o_awready),
		.i_wvalid(i_wvalid), .i_wdata(i_wdata), .o_wready(o_wready),
		.o_bvalid(o_bvalid), .o_bresp(o_bresp), .i_bready(i_bready),
		.i_arvalid(i_arvalid), .i_araddr(i_araddr), .o_arready(o_arready),
		.o_rvalid(o_rvalid), .o_rdata(o_rdata), .o_rresp(o_rresp), .i_rready(i_rready),
		.i_busy(busy), .i_frame_done(frame_done),
		.o_cfg(cfg), .o_frame_start(frame_start)
	);

	vscale_core u_core (
		.clk(clk), .int_resetn(int_resetn),
		.i_cfg(cfg), .i_frame_start(frame_start),
		.i_s_valid(i_s_valid), .i_s_beat(i_s_beat), .o_s_ready(o_s_ready),
		.o_m_valid(o_m_valid), .o_m_beat(o_m_beat), .i_m_ready(i_m_ready),
		.o_fifo_rst(fifo_rst),
		.o_f0_wr_en(f0_wr_en), .o_f0_wr_data(f0_wr_data), .o_f0_rd_en(f0_rd_en),
		.i_f0_rd_data(f0_rd_data), .i_f0_full(f0_full), .i_f0_empty(f0_empty),
		.o_f1_wr_en(f1_wr_en), .o_f1_wr_data(f1_wr_data), .o_f1_rd_en(f1_rd_en),
		.i_f1_rd_data(f1_rd_data), .i_f1_full(f1_full), .i_f1_empty(f1_empty),
		.o_busy(busy), .o_frame_done(frame_done)
	);

	// previous source line
	line_fifo #(.DEPTH(`VSCALE_FIFO_DEPTH)) u_f0 (
		.clk(clk), .int_resetn(int_resetn), .i_clear(fifo_rst),
		.i_wr_en(f0_wr_en), .i_wr_data(f0_wr_data), .i_rd_en(f0_rd_en),
		.o_rd_data(f0_rd_data), .o_full(f0_full), .o_empty(f0_empty)
	);

	// current source line
	line_fifo #(.DEPTH(`VSCALE_FIFO_DEPTH)) u_f1 (
		.clk(clk), .int_resetn(int_resetn), .i_clear(fifo_rst),
		.i_wr_en(f1_wr_en), .i_wr_data(f1_wr_data), .i_rd_en(f1_rd_en),
		.o_rd_data(f1_rd_data), .o_full(f1_full), .o_empty(f1_empty)
	);

endmodule

`default_nettype wire

//--- verif/vscale_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "vscale_defines.svh"

module vscale_tb import vscale_pkg::*; ();

	logic        clk = 1'b0;
	logic        int_resetn;
	logic        awvalid, wvalid, bready, arvalid, rready;
	axil_addr_t  awaddr, araddr;
	axil_data_t  wdata, rdata;
	logic        awready, wready, bvalid, arready, rvalid;
	logic [1:0]  bresp, rresp;
	logic        s_valid, s_ready, m_valid, m_ready;
	pix_beat_t   s_beat, m_beat;

	logic [31:0] lfsr = 32'hb07b_8abe;
	pix_t        src [0:63][0:63];
	int          gap_tab [0:1023];
	bit          stall_tab [0:1023];
	int          gap_idx, stall_idx;
	int          mismatch_cnt, fail_cnt, frames_run, beat_cnt, beats_exp;
	int          cycle_cnt, cycle_limit;

	vscale_top i_dut (
		.clk(clk), .int_resetn(int_resetn),
		.i_awvalid(awvalid), .i_awaddr(awaddr), .o_awready(awready),
		.i_wvalid(wvalid), .i_wdata(wdata), .o_wready(wready),
		.o_bvalid(bvalid), .o_bresp(bresp), .i_bready(bready),
		.i_arvalid(arvalid), .i_araddr(araddr), .o_arready(arready),
		.o_rvalid(rvalid), .o_rdata(rdata), .o_rresp(rresp), .i_rready(rready),
		.i_s_valid(s_valid), .i_s_beat(s_beat), .o_s_ready(s_ready),
		.o_m_valid(m_valid), .o_m_beat(m_beat), .i_m_ready(m_ready)
	);

	always #50 clk = ~clk;

	// fibonacci lfsr on taps 32 22 2 1 stepped once per bit
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	// reference interpolation between the two source lines around output line j
	function automatic int expect_pix(input int h, input int s, input int j, input int x);
		int c, k1, c0, w, p0, p1;
		c = (2 * j + 1) * h;
		k1 = 0;
		while (k1 < h - 1 && (2 * k1 + 1) * s < c) begin
			k1++;
		end
		if (k1 == 0) begin
			return int'(src[0][x]);
		end
		c0 = (2 * k1 - 1) * s;
		w = c - c0;
		if (w > 2 * s) begin
			w = 2 * s;
		end
		p0 = int'(src[k1 - 1][x]);
		p1 = int'(src[k1][x]);
		return p0 + ((p1 - p0) * w) / (2 * s);
	endfunction

	// watchdog
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, the frame did not complete", cycle_cnt);
			$display("errors: mismatches=%0d other=%0d", mismatch_cnt, fail_cnt);
			$display("TB FAILED");
			$finish;
		end
	end

	// every accepted output beat including any stray one
	always @(posedge clk) begin
		if (int_resetn && m_valid && m_ready) begin
			beat_cnt <= beat_cnt + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// axi4-lite master
	////////////////////////////////////////////////////////////

	task automatic write_reg(input axil_addr_t a, input axil_data_t d);
		@(negedge clk);
		awvalid = 1'b1;
		awaddr = a;
		wvalid = 1'b1;
		wdata = d;
		@(posedge clk);
		while (!(awready && wready)) begin
			@(posedge clk);
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		@(posedge clk);
		while (!bvalid) begin
			@(posedge clk);
		end
		assert (bresp == 2'b00) else begin
			mismatch_cnt++;
			$display("MISMATCH bresp addr %h: got %h expected %h", a, bresp, 2'b00);
		end
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic read_reg(input axil_addr_t a, output axil_data_t d);
		@(negedge clk);
		arvalid = 1'b1;
		araddr = a;
		@(posedge clk);
		while (!arready) begin
			@(posedge clk);
		end
		@(negedge clk);
		arvalid = 1'b0;
		rready = 1'b1;
		@(posedge clk);
		while (!rvalid) begin
			@(posedge clk);
		end
		d = rdata;
		assert (rresp == 2'b00) else begin
			mismatch_cnt++;
			$display("MISMATCH rresp addr %h: got %h expected %h", a, rresp, 2'b00);
		end
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic check_reg(input axil_addr_t a, input int v);
		axil_data_t d;
		read_reg(a, d);
		assert (d == axil_data_t'(v)) else begin
			mismatch_cnt++;
			$display("MISMATCH rdata addr %h: got %h expected %h", a, d, axil_data_t'(v));
		end
	endtask

	////////////////////////////////////////////////////////////
	// stream source and sink
	////////////////////////////////////////////////////////////

	task automatic fill_frame(input int w, input int h);
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				src[y][x] = pix_t'(rand_bits(8));
			end
		end
	endtask

	task automatic send_frame(input int w, input int h, input bit gaps);
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				@(negedge clk);
				s_valid = 1'b0;
				if (gaps) begin
					repeat (gap_tab[gap_idx % 1024]) @(negedge clk);
					gap_idx++;
				end
				s_valid = 1'b1;
				s_beat = '{eol: (x == w - 1), sof: (x == 0 && y == 0), data: src[y][x]};
				@(posedge clk);
				while (!s_ready) begin
					@(posedge clk);
				end
			end
		end
		@(negedge clk);
		s_valid = 1'b0;
	endtask

	task automatic recv_frame(input int w, input int h, input int s, input bit stalls);
		int n;
		pix_beat_t exp_b;
		n = 0;
		while (n < w * s) begin
			@(negedge clk);
			m_ready = stalls ? !stall_tab[stall_idx % 1024] : 1'b1;
			stall_idx++;
			@(posedge clk);
			if (m_valid && m_ready) begin
				exp_b.data = pix_t'(expect_pix(h, s, n / w, n % w));
				exp_b.sof = (n == 0);
				exp_b.eol = (n % w == w - 1);
				assert (m_beat.data == exp_b.data) else begin
					mismatch_cnt++;
					$display("MISMATCH m_beat.data beat %0d: got %h expected %h",
						n, m_beat.data, exp_b.data);
				end
				assert (m_beat.sof == exp_b.sof) else begin
					mismatch_cnt++;
					$display("MISMATCH m_beat.sof beat %0d: got %h expected %h",
						n, m_beat.sof, exp_b.sof);
				end
				assert (m_beat.eol == exp_b.eol) else begin
					mismatch_cnt++;
					$display("MISMATCH m_beat.eol beat %0d: got %h expected %h",
						n, m_beat.eol, exp_b.eol);
				end
				n++;
			end
		end
		@(negedge clk);
		m_ready = 1'b1;
	endtask

	task automatic run_frame(input int w, input int h, input int s, input bit stress);
		axil_data_t st;
		write_reg(`VSCALE_REG_OWIDTH, axil_data_t'(w));
		write_reg(`VSCALE_REG_OHEIGHT, axil_data_t'(h));
		write_reg(`VSCALE_REG_SHEIGHT, axil_data_t'(s));
		check_reg(`VSCALE_REG_OWIDTH, w);
		check_reg(`VSCALE_REG_OHEIGHT, h);
		check_reg(`VSCALE_REG_SHEIGHT, s);
		write_reg(`VSCALE_REG_CTRL, 32'h1);
		read_reg(`VSCALE_REG_STATUS, st);
		assert (st[0]) else begin
			fail_cnt++;
			$display("busy flag not set after frame start (%0dx%0d to %0d)", w, h, s);
		end
		beats_exp += w * s;
		fork
			send_frame(w, h, stress);
			recv_frame(w, h, s, stress);
		join
		// busy falls with the last eol
		do begin
			read_reg(`VSCALE_REG_STATUS, st);
		end while (st[0]);
		frames_run++;
		read_reg(`VSCALE_REG_STATUS, st);
		assert (st[15:8] == 8'(frames_run)) else begin
			mismatch_cnt++;
			$display("MISMATCH status frame count: got %h expected %h",
				st[15:8], 8'(frames_run));
		end
		assert (beat_cnt == beats_exp) else begin
			mismatch_cnt++;
			$display("MISMATCH output beat count: got %h expected %h", beat_cnt, beats_exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int w5a, h5a, s5a, w5b, h5b, s5b;
		int_resetn = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		s_valid = 1'b0;
		s_beat = '0;
		m_ready = 1'b0;
		mismatch_cnt = 0;
		fail_cnt = 0;
		frames_run = 0;
		beat_cnt = 0;
		beats_exp = 0;
		cycle_cnt = 0;
		gap_idx = 0;
		stall_idx = 0;
		// back-to-back frames of random, differing sizes
		w5a = 4 + rand_bits(4);
		h5a = 2 + rand_bits(4);
		s5a = 2 + rand_bits(4);
		w5b = 4 + rand_bits(4);
		h5b = 2 + rand_bits(4);
		s5b = 2 + rand_bits(4);
		if (w5b == w5a) begin
			w5b = w5a + 1;
		end
		for (int i = 0; i < 1024; i++) begin
			gap_tab[i] = rand_bits(2);
			stall_tab[i] = (rand_bits(2) == 0);
		end
		cycle_limit = 8 * (2 * 16 * (12 + 5) + 24 * (5 + 11) + w5a * (h5a + s5a) +
			w5b * (h5b + s5b)) + 2000;
		repeat (5) @(posedge clk);
		@(negedge clk);
		int_resetn = 1'b1;

		// downscale and then the same frame again under stalls and gaps
		fill_frame(16, 12);
		run_frame(16, 12, 5, 1'b0);
		run_frame(16, 12, 5, 1'b1);
		// upscale with clamped top and bottom lines
		fill_frame(24, 5);
		run_frame(24, 5, 11, 1'b0);
		fill_frame(w5a, h5a);
		run_frame(w5a, h5a, s5a, 1'b1);
		fill_frame(w5b, h5b);
		run_frame(w5b, h5b, s5b, 1'b1);

		$display("errors: mismatches=%0d other=%0d", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
hdl/vscale_pkg.sv
hdl/line_fifo.sv
hdl/vscale_regs.sv
hdl/vscale_core.sv
hdl/vscale_top.sv
verif/vscale_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the vscale testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module vscale_tb -f flist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vvscale_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
